// File: include/ep0_cfg.svh
`ifndef EP0_CFG_SVH
`define EP0_CFG_SVH

// descriptor ROM, word addressed
`define EP0_ROM_WORDS       32
`define EP0_DESCR_DEV_BASE  5'd0
`define EP0_DESCR_DEV_LEN   16'd18
`define EP0_DESCR_CFG_BASE  5'd5
`define EP0_DESCR_CFG_LEN   16'd25
`define EP0_DESCR_STR0_BASE 5'd12
`define EP0_DESCR_STR0_LEN  16'd4
`define EP0_DESCR_STR1_BASE 5'd13
`define EP0_DESCR_STR1_LEN  16'd10
`define EP0_DESCR_STR2_BASE 5'd16
`define EP0_DESCR_STR2_LEN  16'd10
`define EP0_DESCR_BOS_BASE  5'd19
`define EP0_DESCR_BOS_LEN   16'd22

// video probe block, bus byte order
`define EP0_PROBE_LEN      16'd34
`define EP0_PROBE_RESET_W0 32'h0000_0101
`define EP0_PROBE_RESET_W1 32'h2A2C_0A00
`define EP0_PROBE_RESET_W2 32'h0000_0000
`define EP0_PROBE_RESET_W3 32'h0000_0000
`define EP0_PROBE_RESET_W4 32'h0000_00C6
`define EP0_PROBE_RESET_W5 32'h9900_D049
`define EP0_PROBE_RESET_W6 32'h0000_4059
`define EP0_PROBE_RESET_W7 32'h7307_0000
`define EP0_PROBE_RESET_W8 32'h0000_0000

`define EP0_SELF_POWERED 1'b1

`endif

// File: hw/usb_ctrl_pkg.sv
`default_nettype none

package usb_ctrl_pkg;

	typedef logic [7:0] req_byte_t;

	typedef struct packed {
		req_byte_t   bm_request_type;
		req_byte_t   b_request;
		logic [15:0] w_value;
		logic [15:0] w_index;
		logic [15:0] w_length;
	} setup_pkt_t;

	typedef enum logic [1:0] {kind_standard, kind_class, kind_other} req_kind_t;

	typedef enum logic [2:0] {
		reply_none,
		reply_descr,
		reply_config,
		reply_status,
		reply_probe
	} reply_src_t;

	typedef struct packed {
		logic        start;
		reply_src_t  src;
		req_byte_t   descr_type;
		req_byte_t   descr_index;
		logic [15:0] w_length;
	} reply_req_t;

	typedef struct packed {
		req_byte_t config_value;
		logic      u1_enable;
		logic      u2_enable;
		logic      ltm_enable;
		logic      remote_wakeup;
	} dev_state_t;

	typedef struct packed {
		logic        strobe;
		logic [15:0] num;
		logic [15:0] alt;
	} intf_sel_t;

	// standard requests
	localparam req_byte_t req_get_status        = 8'h00;
	localparam req_byte_t req_set_feature       = 8'h03;
	localparam req_byte_t req_get_descriptor    = 8'h06;
	localparam req_byte_t req_get_configuration = 8'h08;
	localparam req_byte_t req_set_configuration = 8'h09;
	localparam req_byte_t req_set_interface     = 8'h0B;

	// video class
	localparam req_byte_t req_set_cur      = 8'h01;
	localparam req_byte_t req_get_cur      = 8'h81;
	localparam req_byte_t vs_probe_control = 8'h01;

	localparam req_byte_t recipient_device = 8'h00;

	localparam logic [15:0] feat_remote_wakeup = 16'd0;
	localparam logic [15:0] feat_u1_enable     = 16'd48;
	localparam logic [15:0] feat_u2_enable     = 16'd49;
	localparam logic [15:0] feat_ltm_enable    = 16'd50;

	localparam req_byte_t descr_device = 8'd1;
	localparam req_byte_t descr_config = 8'd2;
	localparam req_byte_t descr_string = 8'd3;
	localparam req_byte_t descr_bos    = 8'd15;

endpackage

`default_nettype wire

// File: hw/ep0_buf_pkg.sv
`default_nettype none

package ep0_buf_pkg;

	typedef logic [31:0] buf_word_t;
	typedef logic [10:0] pkt_len_t;
	typedef logic [15:0] xfer_len_t;
	typedef logic [3:0]  word_idx_t;

	typedef struct packed {
		buf_word_t data;
		logic      wren;
		logic      commit;
		pkt_len_t  commit_len;
	} in_buf_t;

	typedef struct packed {
		buf_word_t data;
		pkt_len_t  len;
		logic      has_data;
	} out_buf_t;

endpackage

`default_nettype wire

// File: hw/ep0_request_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module ep0_request_decoder (
	input  wire                      clk,
	input  wire                      rst_n,
	input  wire                      request_active,
	input  wire usb_ctrl_pkg::setup_pkt_t setup,
	output usb_ctrl_pkg::reply_req_t reply_req,
	output usb_ctrl_pkg::dev_state_t dev_state,
	output usb_ctrl_pkg::intf_sel_t  intf_sel,
	output logic                     probe_arm
);
	import usb_ctrl_pkg::*;

	req_kind_t  kind;
	reply_src_t src_c;
	logic       is_std;
	logic       is_class;
	logic       dev_recipient;
	logic       probe_ctl;

	always_comb begin
		case (setup.bm_request_type[6:5])
			2'b00: kind = kind_standard;
			2'b01: kind = kind_class;
			default: kind = kind_other;
		endcase
	end

	assign is_std = kind == kind_standard;
	assign is_class = kind == kind_class;
	assign dev_recipient = setup.w_index[7:0] == recipient_device;
	assign probe_ctl = setup.w_value[15:8] == vs_probe_control;

	// IN-data requests
	always_comb begin
		src_c = reply_none;
		if (is_std) begin
			case (setup.b_request)
				req_get_descriptor: src_c = reply_descr;
				req_get_configuration: src_c = reply_config;
				req_get_status: src_c = reply_status;
				default: src_c = reply_none;
			endcase
		end else if (is_class && probe_ctl && setup.b_request == req_get_cur) begin
			src_c = reply_probe;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			reply_req <= '0;
			dev_state <= '0;
			intf_sel <= '0;
			probe_arm <= 1'b0;
		end else begin
			reply_req.start <= 1'b0;
			intf_sel.strobe <= 1'b0;
			probe_arm <= 1'b0;
			if (request_active) begin
				reply_req.start <= src_c != reply_none;
				reply_req.src <= src_c;
				reply_req.descr_type <= setup.w_value[15:8];
				reply_req.descr_index <= setup.w_value[7:0];
				reply_req.w_length <= setup.w_length;
				if (is_std && setup.b_request == req_set_configuration)
					dev_state.config_value <= setup.w_value[7:0];
				if (is_std && setup.b_request == req_set_interface) begin
					intf_sel.strobe <= 1'b1;
					intf_sel.num <= setup.w_index;
					intf_sel.alt <= setup.w_value;
				end
				// device-level features only, sticky until reset
				if (is_std && setup.b_request == req_set_feature && dev_recipient) begin
					case (setup.w_value)
						feat_u1_enable: dev_state.u1_enable <= 1'b1;
						feat_u2_enable: dev_state.u2_enable <= 1'b1;
						feat_ltm_enable: dev_state.ltm_enable <= 1'b1;
						feat_remote_wakeup: dev_state.remote_wakeup <= setup.w_index[9];
						default: ;
					endcase
				end
				probe_arm <= is_class && probe_ctl && setup.b_request == req_set_cur;
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/descr_rom.sv
`timescale 1ns/100ps
`default_nettype none
`include "ep0_cfg.svh"

module descr_rom (
	input  wire                         clk,
	input  wire usb_ctrl_pkg::req_byte_t descr_type,
	input  wire usb_ctrl_pkg::req_byte_t descr_index,
	output logic                        found,
	output logic [4:0]                  base,
	output ep0_buf_pkg::xfer_len_t      len,
	input  wire [4:0]                   addr,
	output ep0_buf_pkg::buf_word_t      data
);
	import usb_ctrl_pkg::*;
	import ep0_buf_pkg::*;

	buf_word_t mem [`EP0_ROM_WORDS];

	initial begin
		$readmemh("hw/descr_rom.hex", mem);
	end

	always_comb begin
		found = 1'b1;
		base = '0;
		len = '0;
		case (descr_type)
			descr_device: begin
				base = `EP0_DESCR_DEV_BASE;
				len = `EP0_DESCR_DEV_LEN;
			end
			descr_config: begin
				base = `EP0_DESCR_CFG_BASE;
				len = `EP0_DESCR_CFG_LEN;
			end
			descr_string: begin
				case (descr_index)
					8'd0: begin
						base = `EP0_DESCR_STR0_BASE;
						len = `EP0_DESCR_STR0_LEN;
					end
					8'd1: begin
						base = `EP0_DESCR_STR1_BASE;
						len = `EP0_DESCR_STR1_LEN;
					end
					8'd2: begin
						base = `EP0_DESCR_STR2_BASE;
						len = `EP0_DESCR_STR2_LEN;
					end
					default: found = 1'b0;
				endcase
			end
			descr_bos: begin
				base = `EP0_DESCR_BOS_BASE;
				len = `EP0_DESCR_BOS_LEN;
			end
			default: found = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		data <= mem[addr];
	end

endmodule

`default_nettype wire

// File: hw/ep0_in_engine.sv
`timescale 1ns/100ps
`default_nettype none
`include "ep0_cfg.svh"

module ep0_in_engine #(
	parameter int max_pkt_bytes = 512
) (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire usb_ctrl_pkg::reply_req_t reply_req,
	input  wire usb_ctrl_pkg::dev_state_t dev_state,
	input  wire                          rom_found,
	input  wire [4:0]                    rom_base,
	input  wire ep0_buf_pkg::xfer_len_t  rom_len,
	input  wire ep0_buf_pkg::buf_word_t  rom_data,
	output usb_ctrl_pkg::req_byte_t      rom_type,
	output usb_ctrl_pkg::req_byte_t      rom_index,
	output logic [4:0]                   rom_addr,
	output ep0_buf_pkg::word_idx_t       probe_idx,
	input  wire ep0_buf_pkg::buf_word_t  probe_word,
	input  wire                          in_ready,
	output ep0_buf_pkg::in_buf_t         in_buf
);
	import usb_ctrl_pkg::*;
	import ep0_buf_pkg::*;

	typedef enum logic [1:0] {st_idle, st_fetch, st_write, st_commit} state_t;

	state_t     state;
	reply_src_t src_q;
	logic [4:0] base_q;
	logic [4:0] ptr;
	logic [4:0] ptr_nxt;
	xfer_len_t  nat_len;
	xfer_len_t  clamp_len;
	xfer_len_t  remain;
	pkt_len_t   pkt_len_c;
	pkt_len_t   pkt_len;
	pkt_len_t   words_left;
	buf_word_t  word;
	logic       accept;
	logic       wr_fire;

	assign rom_type = reply_req.descr_type;
	assign rom_index = reply_req.descr_index;

	always_comb begin
		case (reply_req.src)
			reply_descr: nat_len = rom_found ? rom_len : '0;
			reply_config: nat_len = 16'd1;
			reply_status: nat_len = 16'd2;
			reply_probe: nat_len = `EP0_PROBE_LEN;
			default: nat_len = '0;
		endcase
	end

	assign clamp_len = (nat_len > reply_req.w_length) ? reply_req.w_length : nat_len;
	// busy engine drops a new start
	assign accept = reply_req.start && state == st_idle && clamp_len != '0;
	assign pkt_len_c = (remain > xfer_len_t'(max_pkt_bytes)) ?
		pkt_len_t'(max_pkt_bytes) : pkt_len_t'(remain);
	assign wr_fire = state == st_write && in_ready;

	// address the word needed next cycle, holds during a stall
	assign ptr_nxt = wr_fire ? ptr + 5'd1 : ptr;
	assign rom_addr = base_q + ptr_nxt;
	assign probe_idx = word_idx_t'(ptr_nxt);

	always_comb begin
		case (src_q)
			reply_descr: word = rom_data;
			reply_config: word = {dev_state.config_value, 24'h0};
			reply_status: word = {3'b000, dev_state.ltm_enable, dev_state.u2_enable,
				dev_state.u1_enable, dev_state.remote_wakeup, `EP0_SELF_POWERED, 24'h0};
			reply_probe: word = probe_word;
			default: word = '0;
		endcase
	end

	always_comb begin
		in_buf.data = word;
		in_buf.wren = wr_fire;
		in_buf.commit = state == st_commit;
		in_buf.commit_len = pkt_len;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
			ptr <= '0;
		end else begin
			ptr <= ptr_nxt;
			case (state)
				st_idle: begin
					if (accept) begin
						state <= st_fetch;
						ptr <= '0;
					end
				end
				st_fetch: state <= st_write;
				st_write: begin
					if (wr_fire && words_left == 11'd1)
						state <= st_commit;
				end
				st_commit: begin
					state <= (remain == xfer_len_t'(pkt_len)) ? st_idle : st_fetch;
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			src_q <= reply_req.src;
			base_q <= rom_base;
			remain <= clamp_len;
		end
		if (state == st_fetch) begin
			pkt_len <= pkt_len_c;
			words_left <= (pkt_len_c + 11'd3) >> 2;
		end
		if (wr_fire)
			words_left <= words_left - 11'd1;
		if (state == st_commit)
			remain <= remain - xfer_len_t'(pkt_len);
	end

endmodule

`default_nettype wire

// File: hw/ep0_out_engine.sv
`timescale 1ns/100ps
`default_nettype none

module ep0_out_engine (
	input  wire                         clk,
	input  wire                         rst_n,
	input  wire ep0_buf_pkg::out_buf_t  out_buf,
	output logic                        rden,
	output logic                        ack,
	output logic                        word_valid,
	output ep0_buf_pkg::word_idx_t      word_idx,
	output ep0_buf_pkg::buf_word_t      word
);
	import ep0_buf_pkg::*;

	logic     busy;
	pkt_len_t rd_left;

	assign rden = busy && rd_left != '0;
	// one cycle after the last read strobe
	assign ack = busy && rd_left == '0;
	assign word = out_buf.data;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			rd_left <= '0;
			word_valid <= 1'b0;
			word_idx <= '0;
		end else begin
			word_valid <= rden;
			if (!busy) begin
				if (out_buf.has_data) begin
					busy <= 1'b1;
					rd_left <= (out_buf.len + 11'd3) >> 2;
				end
			end else if (rden) begin
				rd_left <= rd_left - 11'd1;
			end else begin
				busy <= 1'b0;
			end
			if (!busy)
				word_idx <= '0;
			else if (word_valid)
				word_idx <= word_idx + 4'd1;
		end
	end

endmodule

`default_nettype wire

// File: hw/uvc_probe_store.sv
`timescale 1ns/100ps
`default_nettype none
`include "ep0_cfg.svh"

module uvc_probe_store (
	input  wire                         clk,
	input  wire                         rst_n,
	input  wire                         probe_arm,
	input  wire                         word_valid,
	input  wire ep0_buf_pkg::word_idx_t word_idx,
	input  wire ep0_buf_pkg::buf_word_t word,
	input  wire ep0_buf_pkg::word_idx_t rd_idx,
	output ep0_buf_pkg::buf_word_t      rd_word
);
	import ep0_buf_pkg::*;

	localparam int probe_words = (`EP0_PROBE_LEN + 3) / 4;

	logic      armed;
	logic      commit_q;
	logic      take;
	buf_word_t shadow [probe_words];
	buf_word_t cur [probe_words];

	assign take = armed && word_valid && word_idx < word_idx_t'(probe_words);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			armed <= 1'b0;
			commit_q <= 1'b0;
			cur <= '{`EP0_PROBE_RESET_W0, `EP0_PROBE_RESET_W1, `EP0_PROBE_RESET_W2,
				`EP0_PROBE_RESET_W3, `EP0_PROBE_RESET_W4, `EP0_PROBE_RESET_W5,
				`EP0_PROBE_RESET_W6, `EP0_PROBE_RESET_W7, `EP0_PROBE_RESET_W8};
		end else begin
			commit_q <= 1'b0;
			if (probe_arm) begin
				armed <= 1'b1;
			end else if (take && word_idx == word_idx_t'(probe_words - 1)) begin
				armed <= 1'b0;
				commit_q <= 1'b1;
			end
			// whole block at once
			if (commit_q)
				cur <= shadow;
		end
	end

	always_ff @(posedge clk) begin
		if (take)
			shadow[word_idx] <= word;
		rd_word <= (rd_idx < word_idx_t'(probe_words)) ? cur[rd_idx] : '0;
	end

endmodule

`default_nettype wire

// File: hw/control_transfer.sv
`timescale 1ns/100ps
`default_nettype none

module control_transfer #(
	parameter int max_pkt_bytes = 512
) (
	input  wire                           clk,
	input  wire                           rst_n,
	input  wire                           request_active,
	input  wire usb_ctrl_pkg::setup_pkt_t setup,
	input  wire                           in_ready,
	output ep0_buf_pkg::in_buf_t          in_buf,
	input  wire ep0_buf_pkg::out_buf_t    out_buf,
	output logic                          out_rden,
	output logic                          out_ack,
	output usb_ctrl_pkg::req_byte_t       current_config_value,
	output usb_ctrl_pkg::intf_sel_t       intf_sel
);
	import usb_ctrl_pkg::*;
	import ep0_buf_pkg::*;

	reply_req_t reply_req;
	dev_state_t dev_state;
	logic       probe_arm;
	req_byte_t  rom_type;
	req_byte_t  rom_index;
	logic       rom_found;
	logic [4:0] rom_base;
	xfer_len_t  rom_len;
	logic [4:0] rom_addr;
	buf_word_t  rom_data;
	word_idx_t  probe_idx;
	buf_word_t  probe_word;
	logic       word_valid;
	word_idx_t  word_idx;
	buf_word_t  out_word;

	assign current_config_value = dev_state.config_value;

	ep0_request_decoder u_decoder (
		.clk            (clk),
		.rst_n          (rst_n),
		.request_active (request_active),
		.setup          (setup),
		.reply_req      (reply_req),
		.dev_state      (dev_state),
		.intf_sel       (intf_sel),
		.probe_arm      (probe_arm)
	);

	descr_rom u_rom (
		.clk         (clk),
		.descr_type  (rom_type),
		.descr_index (rom_index),
		.found       (rom_found),
		.base        (rom_base),
		.len         (rom_len),
		.addr        (rom_addr),
		.data        (rom_data)
	);

	ep0_in_engine #(
		.max_pkt_bytes (max_pkt_bytes)
	) u_in (
		.clk        (clk),
		.rst_n      (rst_n),
		.reply_req  (reply_req),
		.dev_state  (dev_state),
		.rom_found  (rom_found),
		.rom_base   (rom_base),
		.rom_len    (rom_len),
		.rom_data   (rom_data),
		.rom_type   (rom_type),
		.rom_index  (rom_index),
		.rom_addr   (rom_addr),
		.probe_idx  (probe_idx),
		.probe_word (probe_word),
		.in_ready   (in_ready),
		.in_buf     (in_buf)
	);

	ep0_out_engine u_out (
		.clk        (clk),
		.rst_n      (rst_n),
		.out_buf    (out_buf),
		.rden       (out_rden),
		.ack        (out_ack),
		.word_valid (word_valid),
		.word_idx   (word_idx),
		.word       (out_word)
	);

	uvc_probe_store u_probe (
		.clk        (clk),
		.rst_n      (rst_n),
		.probe_arm  (probe_arm),
		.word_valid (word_valid),
		.word_idx   (word_idx),
		.word       (out_word),
		.rd_idx     (probe_idx),
		.rd_word    (probe_word)
	);

endmodule

`default_nettype wire

// File: tb/tb_control_transfer.sv
`timescale 1ns/100ps
`default_nettype none
`include "ep0_cfg.svh"

module tb_clock_gen #(
	parameter int period_ns = 40
) (
	output logic clk
);
	initial begin
		clk = 1'b0;
		forever #(period_ns / 2) clk = ~clk;
	end
endmodule

module tb_control_transfer;
	import usb_ctrl_pkg::*;
	import ep0_buf_pkg::*;

	localparam int pkt_bytes = 16;
	localparam int step_limit = 2000;
	localparam int idle_limit = 200;

	logic       clk;
	logic       rst_n;
	logic       request_active;
	setup_pkt_t setup;
	logic       in_ready;
	in_buf_t    in_buf;
	out_buf_t   out_buf;
	logic       out_rden;
	logic       out_ack;
	req_byte_t  current_config_value;
	intf_sel_t  intf_sel;

	buf_word_t   rom_img [`EP0_ROM_WORDS];
	buf_word_t   probe_model [9];
	buf_word_t   exp_words [16];
	buf_word_t   out_words [9];
	buf_word_t   got_words [$];
	pkt_len_t    got_lens [$];
	dev_state_t  state_model;
	integer      seed;
	int          rden_count;
	int          ack_count;
	int          strobe_count;
	logic [15:0] strobe_num;
	logic [15:0] strobe_alt;
	int          rd_ptr;
	int          check_count;
	int          error_count;
	int          timeout_count;

	tb_clock_gen #(
		.period_ns (40)
	) u_clk (
		.clk (clk)
	);

	control_transfer #(
		.max_pkt_bytes (pkt_bytes)
	) u_dut (
		.clk                  (clk),
		.rst_n                (rst_n),
		.request_active       (request_active),
		.setup                (setup),
		.in_ready             (in_ready),
		.in_buf               (in_buf),
		.out_buf              (out_buf),
		.out_rden             (out_rden),
		.out_ack              (out_ack),
		.current_config_value (current_config_value),
		.intf_sel             (intf_sel)
	);

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
			input string what);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic clear_monitor();
		got_words.delete();
		got_lens.delete();
		rden_count = 0;
		ack_count = 0;
		strobe_count = 0;
		rd_ptr = 0;
	endtask

	// sample what the next rising edge will see, then move to the falling edge
	task automatic clock_step();
		logic was_rd;
		#1;
		was_rd = out_rden;
		if (in_buf.wren && !in_ready) begin
			error_count++;
			$display("Fail at %0t: wren is high while in_ready is low", $time);
		end
		if (in_buf.wren)
			got_words.push_back(in_buf.data);
		if (in_buf.commit)
			got_lens.push_back(in_buf.commit_len);
		if (out_rden)
			rden_count++;
		if (out_ack)
			ack_count++;
		if (intf_sel.strobe) begin
			strobe_count++;
			strobe_num = intf_sel.num;
			strobe_alt = intf_sel.alt;
		end
		@(negedge clk);
		in_ready = ($random(seed) & 3) != 0;
		// OUT word is due the cycle after its read strobe
		if (was_rd && rd_ptr < 9) begin
			out_buf.data = out_words[rd_ptr];
			rd_ptr++;
		end
	endtask

	task automatic send_setup(input setup_pkt_t s);
		request_active = 1'b1;
		setup = s;
		clock_step();
		request_active = 1'b0;
	endtask

	function automatic int sum_lens();
		int total;
		total = 0;
		foreach (got_lens[k])
			total += int'(got_lens[k]);
		return total;
	endfunction

	// expected reply words and clamped length from the request rules
	function automatic int build_reply(input setup_pkt_t s);
		int  nat;
		int  base;
		int  i;
		logic is_std;
		is_std = s.bm_request_type[6:5] == 2'b00;
		nat = 0;
		base = 0;
		for (i = 0; i < 16; i++)
			exp_words[i] = '0;
		if (is_std && s.b_request == req_get_descriptor) begin
			case (s.w_value[15:8])
				descr_device: begin
					base = int'(`EP0_DESCR_DEV_BASE);
					nat = int'(`EP0_DESCR_DEV_LEN);
				end
				descr_config: begin
					base = int'(`EP0_DESCR_CFG_BASE);
					nat = int'(`EP0_DESCR_CFG_LEN);
				end
				descr_string: begin
					if (s.w_value[7:0] == 8'd0) begin
						base = int'(`EP0_DESCR_STR0_BASE);
						nat = int'(`EP0_DESCR_STR0_LEN);
					end else if (s.w_value[7:0] == 8'd1) begin
						base = int'(`EP0_DESCR_STR1_BASE);
						nat = int'(`EP0_DESCR_STR1_LEN);
					end else if (s.w_value[7:0] == 8'd2) begin
						base = int'(`EP0_DESCR_STR2_BASE);
						nat = int'(`EP0_DESCR_STR2_LEN);
					end
				end
				descr_bos: begin
					base = int'(`EP0_DESCR_BOS_BASE);
					nat = int'(`EP0_DESCR_BOS_LEN);
				end
				default: nat = 0;
			endcase
			for (i = 0; i < 8; i++)
				exp_words[i] = rom_img[(base + i) % `EP0_ROM_WORDS];
		end else if (is_std && s.b_request == req_get_configuration) begin
			nat = 1;
			exp_words[0] = {state_model.config_value, 24'h0};
		end else if (is_std && s.b_request == req_get_status) begin
			nat = 2;
			exp_words[0] = {3'b000, state_model.ltm_enable, state_model.u2_enable,
				state_model.u1_enable, state_model.remote_wakeup, `EP0_SELF_POWERED, 24'h0};
		end else if (s.bm_request_type[6:5] == 2'b01 && s.b_request == req_get_cur &&
				s.w_value[15:8] == vs_probe_control) begin
			nat = int'(`EP0_PROBE_LEN);
			for (i = 0; i < 9; i++)
				exp_words[i] = probe_model[i];
		end
		return (nat < int'(s.w_length)) ? nat : int'(s.w_length);
	endfunction

	task automatic update_model(input setup_pkt_t s);
		if (s.bm_request_type[6:5] == 2'b00) begin
			if (s.b_request == req_set_configuration)
				state_model.config_value = s.w_value[7:0];
			if (s.b_request == req_set_feature && s.w_index[7:0] == 8'h00) begin
				case (s.w_value)
					feat_u1_enable: state_model.u1_enable = 1'b1;
					feat_u2_enable: state_model.u2_enable = 1'b1;
					feat_ltm_enable: state_model.ltm_enable = 1'b1;
					feat_remote_wakeup: state_model.remote_wakeup = s.w_index[9];
					default: ;
				endcase
			end
		end
	endtask

	task automatic run_in(input setup_pkt_t s, input int file_bytes);
		int exp_len;
		int remain;
		int steps;
		exp_len = build_reply(s);
		check_value(32'(file_bytes), 32'(exp_len), "cases file byte count");
		clear_monitor();
		send_setup(s);
		steps = 0;
		if (exp_len == 0) begin
			while (steps < idle_limit) begin
				clock_step();
				steps++;
			end
		end else begin
			while (sum_lens() < exp_len && steps < step_limit) begin
				clock_step();
				steps++;
			end
			if (sum_lens() < exp_len) begin
				error_count++;
				timeout_count++;
				$display("Timeout at %0t: reply of %0d bytes did not finish", $time, exp_len);
			end
			// catch stray words or commits after the last packet
			repeat (4) clock_step();
		end
		check_value(32'(got_lens.size()), 32'((exp_len + pkt_bytes - 1) / pkt_bytes),
			"commit count");
		remain = exp_len;
		foreach (got_lens[k]) begin
			check_value(32'(got_lens[k]), 32'((remain > pkt_bytes) ? pkt_bytes : remain),
				"commit_len");
			remain = (remain > pkt_bytes) ? remain - pkt_bytes : 0;
		end
		check_value(32'(got_words.size()), 32'((exp_len + 3) / 4), "IN word count");
		foreach (got_words[k]) begin
			if (k < 16)
				check_value(got_words[k], exp_words[k], "IN word");
		end
	endtask

	task automatic run_no_data(input setup_pkt_t s, input int file_bytes);
		check_value(32'(file_bytes), 32'd0, "cases file byte count");
		update_model(s);
		clear_monitor();
		send_setup(s);
		repeat (4) clock_step();
		check_value(32'(current_config_value), 32'(state_model.config_value),
			"current_config_value");
		if (s.bm_request_type[6:5] == 2'b00 && s.b_request == req_set_interface) begin
			check_value(32'(strobe_count), 32'd1, "intf_sel strobe count");
			check_value(32'(strobe_num), 32'(s.w_index), "intf_sel num");
			check_value(32'(strobe_alt), 32'(s.w_value), "intf_sel alt");
		end else begin
			check_value(32'(strobe_count), 32'd0, "intf_sel strobe count");
		end
		check_value(32'(got_lens.size()), 32'd0, "commit count");
	endtask

	task automatic run_probe_write(input setup_pkt_t s, input int file_bytes);
		int steps;
		int i;
		for (i = 0; i < 9; i++)
			out_words[i] = $random(seed);
		clear_monitor();
		send_setup(s);
		clock_step();
		out_buf.len = pkt_len_t'(file_bytes);
		out_buf.has_data = 1'b1;
		clock_step();
		out_buf.has_data = 1'b0;
		steps = 0;
		while (ack_count == 0 && steps < step_limit) begin
			clock_step();
			steps++;
		end
		if (ack_count == 0) begin
			error_count++;
			timeout_count++;
			$display("Timeout at %0t: OUT packet was never acknowledged", $time);
		end
		repeat (4) clock_step();
		check_value(32'(rden_count), 32'((file_bytes + 3) / 4), "out_rden cycles");
		check_value(32'(ack_count), 32'd1, "out_ack pulses");
		for (i = 0; i < 9; i++)
			probe_model[i] = out_words[i];
	endtask

	initial begin
		string      line;
		int         fd;
		int         n;
		int         op;
		int         bm;
		int         breq;
		int         wv;
		int         wi;
		int         wl;
		int         nb;
		int         case_count;
		setup_pkt_t s;
		seed = 32'h30d0;
		rst_n = 1'b0;
		request_active = 1'b0;
		setup = '0;
		in_ready = 1'b0;
		out_buf = '0;
		check_count = 0;
		error_count = 0;
		timeout_count = 0;
		case_count = 0;
		state_model = '0;
		probe_model = '{`EP0_PROBE_RESET_W0, `EP0_PROBE_RESET_W1, `EP0_PROBE_RESET_W2,
			`EP0_PROBE_RESET_W3, `EP0_PROBE_RESET_W4, `EP0_PROBE_RESET_W5,
			`EP0_PROBE_RESET_W6, `EP0_PROBE_RESET_W7, `EP0_PROBE_RESET_W8};
		$readmemh("hw/descr_rom.hex", rom_img);
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		// quiet outputs while nothing is requested
		clear_monitor();
		repeat (8) clock_step();
		check_value(32'(got_words.size()), 32'd0, "wren after reset");
		check_value(32'(got_lens.size()), 32'd0, "commit after reset");
		check_value(32'(rden_count), 32'd0, "out_rden after reset");
		check_value(32'(ack_count), 32'd0, "out_ack after reset");
		check_value(32'(strobe_count), 32'd0, "intf_sel strobe after reset");

		fd = $fopen("tb/ep0_cases.txt", "r");
		if (fd == 0) begin
			error_count++;
			$display("Could not open the cases file tb/ep0_cases.txt");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				n = $fgets(line, fd);
				// comment and blank lines do not scan
				if (n > 0 && $sscanf(line, "%h %h %h %h %h %h %h",
						op, bm, breq, wv, wi, wl, nb) == 7) begin
					s.bm_request_type = bm[7:0];
					s.b_request = breq[7:0];
					s.w_value = wv[15:0];
					s.w_index = wi[15:0];
					s.w_length = wl[15:0];
					case_count++;
					case (op)
						1: run_in(s, nb);
						2: run_no_data(s, nb);
						3: run_probe_write(s, nb);
						default: begin
							error_count++;
							$display("Unknown operation code %0d in the cases file", op);
						end
					endcase
				end
			end
			$fclose(fd);
		end
		if (case_count == 0) begin
			error_count++;
			$display("No cases were read from the cases file");
		end

		$display("cases %0d, checks %0d, errors %0d, timeouts %0d",
			case_count, check_count, error_count, timeout_count);
		if (error_count == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: hw/descr_rom.hex
// descriptor bytes, four per word, first byte in bits 31:24
12012003
EF020109
B404F100
00010102
00010000
09021900
010100C0
00090400
00000E01
00000724
01000100
00000000
04030904
0A035500
56004300
33000000
0A034300
41004D00
30000000
050F1600
02071002
00000000
0A100300
0E00010A
FF070000
00000000
00000000
00000000
00000000
00000000
00000000
00000000

// File: tb/ep0_cases.txt
# op bmRequestType bRequest wValue wIndex wLength bytes, all hex
# op 1 = IN reply, 2 = no data stage, 3 = SET_CUR then OUT packet of the given bytes
1 80 08 0000 0000 0001 01  GET_CONFIGURATION after reset
1 80 06 0100 0000 00ff 12  device descriptor
1 80 06 0200 0000 00ff 19  configuration descriptor
1 80 06 0300 0000 00ff 04  string 0
1 80 06 0f00 0000 00ff 16  BOS
1 80 06 0100 0000 0008 08  device, short wLength
1 80 06 0307 0000 00ff 00  string 7, not in table
1 80 06 0100 0000 0000 00  wLength 0
2 00 09 0001 0000 0000 00  SET_CONFIGURATION 1
1 80 08 0000 0000 0001 01  GET_CONFIGURATION
2 01 0b 0002 0001 0000 00  SET_INTERFACE num 1 alt 2
2 00 03 0030 0000 0000 00  SET_FEATURE U1
2 00 03 0031 0000 0000 00  SET_FEATURE U2
1 80 00 0000 0000 0002 02  GET_STATUS
1 a1 81 0100 0001 0022 22  GET_CUR probe, reset words
3 21 01 0100 0001 0022 22  SET_CUR probe with OUT packet
1 a1 81 0100 0001 0022 22  GET_CUR probe, new words

// File: verilog.f
+incdir+include
hw/usb_ctrl_pkg.sv
hw/ep0_buf_pkg.sv
hw/ep0_request_decoder.sv
hw/descr_rom.sv
hw/ep0_in_engine.sv
hw/ep0_out_engine.sv
hw/uvc_probe_store.sv
hw/control_transfer.sv
tb/tb_control_transfer.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_control_transfer
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --timescale 1ns/100ps

SOURCES := $(shell grep -v '^+' verilog.f)
HEADERS := $(wildcard include/*.svh)
SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): verilog.f $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) -f verilog.f --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@if grep -q "Testbench failed" $(LOG); then exit 1; fi
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
